/* soc_defines.svh */
`ifndef SOC_DEFINES_SVH
`define SOC_DEFINES_SVH

// bus geometry
`define SOC_DATA_W      32
`define SOC_BE_W        4

// index width of one ram bank, 1024 words each
`define RAM_WORD_AW     10

// top address byte
`define SEG_RAM         8'h80
`define SEG_IO          8'hBF

// device codes inside the io segment
`define DEV_TICKER      8'h01
`define DEV_GPIO        8'h02

// ticker register indices
`define TICK_REG_COUNT  6'd0
`define TICK_REG_CTRL   6'd1

// gpio register indices
`define GPIO_REG_OUT    6'd0
`define GPIO_REG_IN     6'd1

`endif

/* soc_pkg.sv */
`default_nettype none

package soc_pkg;

    // one bus address word, read as ram or io depending on the segment
    typedef union packed {
        struct packed {
            logic [7:0]  segment;   // top byte, SEG_RAM
            logic        spare;
            logic        bank;      // bit 22, base or ext bank
            logic [19:0] word_idx;  // aliased modulo bank depth
            logic [1:0]  byte_off;
        } ram_view;
        struct packed {
            logic [7:0]  segment;   // top byte, SEG_IO
            logic [7:0]  spare;
            logic [7:0]  device;    // ticker or gpio
            logic [5:0]  reg_idx;
            logic [1:0]  byte_off;
        } io_view;
    } bus_addr_u;

    // target chosen by the decoder
    typedef enum logic [1:0] {
        TGT_NONE   = 2'd0,
        TGT_RAM    = 2'd1,
        TGT_TICKER = 2'd2,
        TGT_GPIO   = 2'd3
    } target_e;

endpackage

`default_nettype wire

/* bus_decoder.sv */
`include "soc_defines.svh"
`timescale 1ns/1ps
`default_nettype none

module bus_decoder (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  soc_pkg::bus_addr_u     bus_addr_i,
    input  logic                   bus_read_i,
    input  logic                   bus_write_i,
    output logic                   ram_rd_o,
    output logic                   ram_wr_o,
    output logic                   tick_rd_o,
    output logic                   tick_wr_o,
    output logic                   gpio_rd_o,
    output logic                   gpio_wr_o,
    input  logic [`SOC_DATA_W-1:0] ram_rdata_i,
    input  logic [`SOC_DATA_W-1:0] tick_rdata_i,
    input  logic [`SOC_DATA_W-1:0] gpio_rdata_i,
    output logic [`SOC_DATA_W-1:0] bus_rdata_o,
    output logic                   bus_rvalid_o
);

    soc_pkg::target_e tgt;        // target of this cycle's strobe
    soc_pkg::target_e rd_tgt_q;   // target of the read in flight
    logic             rvalid_q;

    always_comb begin
        tgt = soc_pkg::TGT_NONE;
        if (bus_addr_i.io_view.segment == `SEG_RAM) begin
            tgt = soc_pkg::TGT_RAM;
        end else if (bus_addr_i.io_view.segment == `SEG_IO) begin
            case (bus_addr_i.io_view.device)
                `DEV_TICKER: tgt = soc_pkg::TGT_TICKER;
                `DEV_GPIO:   tgt = soc_pkg::TGT_GPIO;
                default:     tgt = soc_pkg::TGT_NONE;   // unknown device
            endcase
        end
    end

    // strobe goes to exactly one target, or nowhere
    assign ram_rd_o  = bus_read_i  & (tgt == soc_pkg::TGT_RAM);
    assign ram_wr_o  = bus_write_i & (tgt == soc_pkg::TGT_RAM);
    assign tick_rd_o = bus_read_i  & (tgt == soc_pkg::TGT_TICKER);
    assign tick_wr_o = bus_write_i & (tgt == soc_pkg::TGT_TICKER);
    assign gpio_rd_o = bus_read_i  & (tgt == soc_pkg::TGT_GPIO);
    assign gpio_wr_o = bus_write_i & (tgt == soc_pkg::TGT_GPIO);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rd_tgt_q <= soc_pkg::TGT_NONE;
            rvalid_q <= 1'b0;
        end else begin
            rd_tgt_q <= bus_read_i ? tgt : soc_pkg::TGT_NONE;   // idle cycles read as none
            rvalid_q <= bus_read_i;
        end
    end

    // targets hold their registered word, pick it one cycle after the strobe
    always_comb begin
        case (rd_tgt_q)
            soc_pkg::TGT_RAM:    bus_rdata_o = ram_rdata_i;
            soc_pkg::TGT_TICKER: bus_rdata_o = tick_rdata_i;
            soc_pkg::TGT_GPIO:   bus_rdata_o = gpio_rdata_i;
            default:             bus_rdata_o = '0;   // unmapped or no read
        endcase
    end

    assign bus_rvalid_o = rvalid_q;

endmodule

`default_nettype wire

/* onchip_ram.sv */
`include "soc_defines.svh"
`timescale 1ns/1ps
`default_nettype none

module onchip_ram (
    input  logic                   clk_i,
    input  soc_pkg::bus_addr_u     addr_i,
    input  logic [`SOC_BE_W-1:0]   be_i,
    input  logic [`SOC_DATA_W-1:0] wdata_i,
    input  logic                   rd_i,
    input  logic                   wr_i,
    output logic [`SOC_DATA_W-1:0] rdata_o
);

    localparam int RAM_WORDS = 1 << `RAM_WORD_AW;

    // bank 0 is base ram, bank 1 is ext ram
    logic [`SOC_DATA_W-1:0]  mem_q [0:1][0:RAM_WORDS-1];
    logic [`RAM_WORD_AW-1:0] word_idx;
    logic                    bank;
    logic [`SOC_DATA_W-1:0]  rdata_q;

    assign bank     = addr_i.ram_view.bank;                          // address bit 22
    assign word_idx = addr_i.ram_view.word_idx[`RAM_WORD_AW-1:0];   // upper bits alias

    // byte lane write
    always_ff @(posedge clk_i) begin
        if (wr_i) begin
            for (int b = 0; b < `SOC_BE_W; b++) begin
                if (be_i[b]) begin
                    mem_q[bank][word_idx][b*8 +: 8] <= wdata_i[b*8 +: 8];
                end
            end
        end
    end

    // registered read, held until the next read
    always_ff @(posedge clk_i) begin
        if (rd_i) begin
            rdata_q <= mem_q[bank][word_idx];
        end
    end

    assign rdata_o = rdata_q;

endmodule

`default_nettype wire

/* ticker_timer.sv */
`include "soc_defines.svh"
`timescale 1ns/1ps
`default_nettype none

module ticker_timer (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic [5:0]             reg_idx_i,
    input  logic [`SOC_DATA_W-1:0] wdata_i,
    input  logic                   rd_i,
    input  logic                   wr_i,
    output logic [`SOC_DATA_W-1:0] rdata_o
);

    logic [`SOC_DATA_W-1:0] count_q;
    logic                   enable_q;
    logic [`SOC_DATA_W-1:0] rdata_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            count_q  <= '0;
            enable_q <= 1'b1;   // counts from reset
        end else begin
            if (wr_i && reg_idx_i == `TICK_REG_COUNT) begin
                count_q <= wdata_i;   // load wins over increment, be ignored
            end else if (enable_q) begin
                count_q <= count_q + 1'b1;
            end
            if (wr_i && reg_idx_i == `TICK_REG_CTRL) begin
                enable_q <= wdata_i[0];
            end
        end
    end

    // read sees the count from before this edge
    always_ff @(posedge clk_i) begin
        if (rd_i) begin
            case (reg_idx_i)
                `TICK_REG_COUNT: rdata_q <= count_q;
                `TICK_REG_CTRL:  rdata_q <= {{(`SOC_DATA_W-1){1'b0}}, enable_q};
                default:         rdata_q <= '0;   // unknown register
            endcase
        end
    end

    assign rdata_o = rdata_q;

endmodule

`default_nettype wire

/* gpio_port.sv */
`include "soc_defines.svh"
`timescale 1ns/1ps
`default_nettype none

module gpio_port (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic [5:0]             reg_idx_i,
    input  logic [`SOC_BE_W-1:0]   be_i,
    input  logic [`SOC_DATA_W-1:0] wdata_i,
    input  logic                   rd_i,
    input  logic                   wr_i,
    input  logic [`SOC_DATA_W-1:0] gpio_in_i,
    output logic [`SOC_DATA_W-1:0] gpio_out_o,
    output logic [`SOC_DATA_W-1:0] rdata_o
);

    logic [`SOC_DATA_W-1:0] out_q;
    logic [`SOC_DATA_W-1:0] rdata_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            out_q <= '0;
        end else if (wr_i && reg_idx_i == `GPIO_REG_OUT) begin
            for (int b = 0; b < `SOC_BE_W; b++) begin
                if (be_i[b]) begin
                    out_q[b*8 +: 8] <= wdata_i[b*8 +: 8];   // per lane
                end
            end
        end
    end

    // input word is sampled at the strobe edge
    always_ff @(posedge clk_i) begin
        if (rd_i) begin
            case (reg_idx_i)
                `GPIO_REG_OUT: rdata_q <= out_q;
                `GPIO_REG_IN:  rdata_q <= gpio_in_i;
                default:       rdata_q <= '0;
            endcase
        end
    end

    assign gpio_out_o = out_q;
    assign rdata_o    = rdata_q;

endmodule

`default_nettype wire

/* soc_bus_top.sv */
`include "soc_defines.svh"
`timescale 1ns/1ps
`default_nettype none

module soc_bus_top (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  soc_pkg::bus_addr_u     bus_addr_i,
    input  logic [`SOC_BE_W-1:0]   bus_be_i,
    input  logic [`SOC_DATA_W-1:0] bus_wdata_i,
    input  logic                   bus_read_i,
    input  logic                   bus_write_i,
    input  logic [`SOC_DATA_W-1:0] gpio_in_i,
    output logic [`SOC_DATA_W-1:0] bus_rdata_o,
    output logic                   bus_rvalid_o,
    output logic [`SOC_DATA_W-1:0] gpio_out_o
);

    // decoder to targets
    logic                   ram_rd;
    logic                   ram_wr;
    logic                   tick_rd;
    logic                   tick_wr;
    logic                   gpio_rd;
    logic                   gpio_wr;

    // targets to decoder
    logic [`SOC_DATA_W-1:0] ram_rdata;
    logic [`SOC_DATA_W-1:0] tick_rdata;
    logic [`SOC_DATA_W-1:0] gpio_rdata;

    bus_decoder i_bus_decoder (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .bus_addr_i   (bus_addr_i),
        .bus_read_i   (bus_read_i),
        .bus_write_i  (bus_write_i),
        .ram_rd_o     (ram_rd),
        .ram_wr_o     (ram_wr),
        .tick_rd_o    (tick_rd),
        .tick_wr_o    (tick_wr),
        .gpio_rd_o    (gpio_rd),
        .gpio_wr_o    (gpio_wr),
        .ram_rdata_i  (ram_rdata),
        .tick_rdata_i (tick_rdata),
        .gpio_rdata_i (gpio_rdata),
        .bus_rdata_o  (bus_rdata_o),
        .bus_rvalid_o (bus_rvalid_o)
    );

    onchip_ram i_onchip_ram (
        .clk_i   (clk_i),
        .addr_i  (bus_addr_i),
        .be_i    (bus_be_i),
        .wdata_i (bus_wdata_i),
        .rd_i    (ram_rd),
        .wr_i    (ram_wr),
        .rdata_o (ram_rdata)
    );

    ticker_timer i_ticker_timer (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .reg_idx_i (bus_addr_i.io_view.reg_idx),
        .wdata_i   (bus_wdata_i),
        .rd_i      (tick_rd),
        .wr_i      (tick_wr),
        .rdata_o   (tick_rdata)
    );

    gpio_port i_gpio_port (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .reg_idx_i  (bus_addr_i.io_view.reg_idx),
        .be_i       (bus_be_i),
        .wdata_i    (bus_wdata_i),
        .rd_i       (gpio_rd),
        .wr_i       (gpio_wr),
        .gpio_in_i  (gpio_in_i),
        .gpio_out_o (gpio_out_o),
        .rdata_o    (gpio_rdata)
    );

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #4 clk_o = ~clk_o;   // 8 ns period
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (3) @(posedge clk_o);
        rst_n_o <= 1'b1;   // low for three edges
    end

endmodule

`default_nettype wire

/* soc_bus_checker.sv */
`include "soc_defines.svh"
`timescale 1ns/1ps
`default_nettype none

module soc_bus_checker (
    input logic                   clk_i,
    input logic                   rst_n_i,
    input logic                   bus_read_i,
    input logic                   bus_write_i,
    input logic                   rvalid_i,
    input logic [`SOC_DATA_W-1:0] gpio_out_i
);

    int fail_cnt = 0;   // read back by the testbench top

    assert property (@(posedge clk_i) disable iff (!rst_n_i) bus_read_i |=> rvalid_i)
        else begin
            fail_cnt++;
            $error("rvalid missing in the cycle after a read strobe");
        end

    assert property (@(posedge clk_i) disable iff (!rst_n_i) !bus_read_i |=> !rvalid_i)
        else begin
            fail_cnt++;
            $error("rvalid high without a read strobe in the cycle before");
        end

    assert property (@(posedge clk_i) !(bus_read_i && bus_write_i))
        else begin
            fail_cnt++;
            $error("read and write strobes high together");
        end

    // outputs cleared by every reset edge
    assert property (@(posedge clk_i) !rst_n_i |=> (!rvalid_i && gpio_out_i == '0))
        else begin
            fail_cnt++;
            $error("rvalid or gpio_out not zero after a reset cycle");
        end

endmodule

`default_nettype wire

/* tb_monitor.sv */
`include "soc_defines.svh"
`timescale 1ns/1ps
`default_nettype none

module tb_monitor (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic [31:0] bus_addr_i,
    input  logic [3:0]  bus_be_i,
    input  logic [31:0] bus_wdata_i,
    input  logic        bus_read_i,
    input  logic        bus_write_i,
    input  logic [31:0] gpio_in_i,
    input  logic [31:0] bus_rdata_i,
    input  logic        bus_rvalid_i,
    input  logic [31:0] gpio_out_i,
    output int          err_cnt_o
);

    logic [31:0] ram_m [0:1][0:1023];   // bank, word index
    logic [31:0] count_m;
    logic        enable_m;
    logic [31:0] out_m;
    logic [31:0] exp_q;
    logic        pending = 1'b0;        // answer due in this cycle
    logic        armed = 1'b0;          // set by the first reset edge
    int          errs = 0;

    assign err_cnt_o = errs;

    function automatic logic [31:0] merge_lanes(input logic [31:0] old_w,
                                                input logic [31:0] new_w,
                                                input logic [3:0]  be);
        logic [31:0] w;
        w = old_w;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                w[b*8 +: 8] = new_w[b*8 +: 8];
            end
        end
        return w;
    endfunction

    always @(posedge clk_i) begin : model
        logic [5:0]  ridx;
        logic        is_tick;
        logic        is_gpio;
        logic [31:0] exp;
        ridx    = bus_addr_i[7:2];
        is_tick = bus_addr_i[31:24] == `SEG_IO && bus_addr_i[15:8] == `DEV_TICKER;
        is_gpio = bus_addr_i[31:24] == `SEG_IO && bus_addr_i[15:8] == `DEV_GPIO;
        if (armed) begin
            if (bus_rvalid_i !== pending) begin
                errs++;
                $display("FAIL %0t: rvalid %b, expected %b", $time, bus_rvalid_i, pending);
            end else if (bus_rdata_i !== (pending ? exp_q : 32'd0)) begin
                errs++;
                $display("FAIL %0t: rdata %h, expected %h", $time, bus_rdata_i,
                         pending ? exp_q : 32'd0);
            end
            if (gpio_out_i !== out_m) begin
                errs++;
                $display("FAIL %0t: gpio_out %h, expected %h", $time, gpio_out_i, out_m);
            end
        end
        if (!rst_n_i) begin
            count_m  = '0;
            enable_m = 1'b1;
            out_m    = '0;
            pending  = 1'b0;
            armed    = 1'b1;
        end else begin
            // value seen by a read, state before this edge
            exp = '0;
            if (bus_addr_i[31:24] == `SEG_RAM) begin
                exp = ram_m[bus_addr_i[22]][bus_addr_i[11:2]];   // index mod 1024
            end else if (is_tick && ridx == `TICK_REG_COUNT) begin
                exp = count_m;
            end else if (is_tick && ridx == `TICK_REG_CTRL) begin
                exp = {31'd0, enable_m};
            end else if (is_gpio && ridx == `GPIO_REG_OUT) begin
                exp = out_m;
            end else if (is_gpio && ridx == `GPIO_REG_IN) begin
                exp = gpio_in_i;
            end
            pending = bus_read_i;
            exp_q   = exp;
            if (bus_write_i && is_tick && ridx == `TICK_REG_COUNT) begin
                count_m = bus_wdata_i;   // load, all lanes
            end else if (enable_m) begin
                count_m = count_m + 32'd1;
            end
            if (bus_write_i && is_tick && ridx == `TICK_REG_CTRL) begin
                enable_m = bus_wdata_i[0];
            end
            if (bus_write_i && bus_addr_i[31:24] == `SEG_RAM) begin
                ram_m[bus_addr_i[22]][bus_addr_i[11:2]] =
                    merge_lanes(ram_m[bus_addr_i[22]][bus_addr_i[11:2]], bus_wdata_i, bus_be_i);
            end
            if (bus_write_i && is_gpio && ridx == `GPIO_REG_OUT) begin
                out_m = merge_lanes(out_m, bus_wdata_i, bus_be_i);
            end
        end
    end

endmodule

`default_nettype wire

/* tb_soc_bus.sv */
`include "soc_defines.svh"
`timescale 1ns/1ps
`default_nettype none

module tb_soc_bus;

    localparam int N_OPS      = 2000;
    localparam int FILL_OPS   = 32;
    localparam int MAX_GAP    = 3;
    // every op takes at most 1 + MAX_GAP cycles of 8 ns
    localparam int TIMEOUT_NS = (N_OPS + FILL_OPS) * (MAX_GAP + 1) * 8 + 2000;

    logic        clk;
    logic        rst_n;
    logic [31:0] bus_addr;
    logic [3:0]  bus_be;
    logic [31:0] bus_wdata;
    logic        bus_read;
    logic        bus_write;
    logic [31:0] gpio_in;
    logic [31:0] bus_rdata;
    logic        bus_rvalid;
    logic [31:0] gpio_out;
    int          mismatches;
    int          assert_fails;
    int          seed = 32'ha25b67d2;

    tb_clock_gen i_clock_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    soc_bus_top i_dut (
        .clk_i        (clk),
        .rst_n_i      (rst_n),
        .bus_addr_i   (bus_addr),
        .bus_be_i     (bus_be),
        .bus_wdata_i  (bus_wdata),
        .bus_read_i   (bus_read),
        .bus_write_i  (bus_write),
        .gpio_in_i    (gpio_in),
        .bus_rdata_o  (bus_rdata),
        .bus_rvalid_o (bus_rvalid),
        .gpio_out_o   (gpio_out)
    );

    tb_monitor i_monitor (
        .clk_i        (clk),
        .rst_n_i      (rst_n),
        .bus_addr_i   (bus_addr),
        .bus_be_i     (bus_be),
        .bus_wdata_i  (bus_wdata),
        .bus_read_i   (bus_read),
        .bus_write_i  (bus_write),
        .gpio_in_i    (gpio_in),
        .bus_rdata_i  (bus_rdata),
        .bus_rvalid_i (bus_rvalid),
        .gpio_out_i   (gpio_out),
        .err_cnt_o    (mismatches)
    );

    bind soc_bus_top soc_bus_checker i_soc_bus_checker (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .bus_read_i  (bus_read_i),
        .bus_write_i (bus_write_i),
        .rvalid_i    (bus_rvalid_o),
        .gpio_out_i  (gpio_out_o)
    );

    // one strobe cycle followed by gap idle cycles
    task automatic issue(input logic [31:0] addr, input logic rd, input logic [3:0] be,
                         input logic [31:0] data, input int gap);
        @(posedge clk);
        bus_addr  <= addr;
        bus_read  <= rd;
        bus_write <= !rd;
        bus_be    <= be;
        bus_wdata <= data;
        gpio_in   <= $random(seed);
        repeat (gap) begin
            @(posedge clk);
            bus_read  <= 1'b0;
            bus_write <= 1'b0;
        end
    endtask

    task automatic random_addr(output logic [31:0] addr);
        logic [31:0] r;
        logic [31:0] s;
        logic [7:0]  seg;
        r = $random(seed);
        s = $random(seed);
        seg = (s[31:24] == `SEG_RAM || s[31:24] == `SEG_IO) ? 8'h00 : s[31:24];
        case (r[2:0])
            // random bank and alias bits with an index below 16
            3'd0, 3'd1, 3'd2: addr = {`SEG_RAM, s[1:0], s[11:2], 6'd0, r[7:4], s[13:12]};
            3'd3:             addr = {`SEG_IO, s[7:0], `DEV_TICKER, 4'd0, r[5:4], s[9:8]};
            3'd4, 3'd5:       addr = {`SEG_IO, s[7:0], `DEV_GPIO, 4'd0, r[5:4], s[9:8]};
            3'd6:             addr = {`SEG_IO, s[15:8], 8'h10, s[7:0]};   // no such device
            default:          addr = {seg, s[23:0]};                      // unmapped segment
        endcase
    endtask

    initial begin : stimulus
        logic [31:0] addr;
        logic [31:0] r;
        bus_addr  = '0;
        bus_be    = '0;
        bus_wdata = '0;
        bus_read  = 1'b0;
        bus_write = 1'b0;
        gpio_in   = '0;
        wait (rst_n === 1'b1);
        issue({`SEG_IO, 8'h00, `DEV_TICKER, 8'h00}, 1'b1, 4'hf, 32'd0, 1);   // first count read
        for (int i = 0; i < FILL_OPS; i++) begin
            issue({`SEG_RAM, 1'b0, i[4], 10'd0, 6'd0, i[3:0], 2'b00}, 1'b0, 4'hf,
                  $random(seed), 0);
        end
        for (int n = 0; n < N_OPS; n++) begin
            random_addr(addr);
            r = $random(seed);
            issue(addr, r[0], r[7:4], $random(seed), {30'd0, r[9:8]});
        end
        @(posedge clk);
        bus_read  <= 1'b0;
        bus_write <= 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);   // last edge fully compared
        assert_fails = i_dut.i_soc_bus_checker.fail_cnt;
        $display("mismatches %0d, assertion failures %0d", mismatches, assert_fails);
        if (mismatches == 0 && assert_fails == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("run timed out, operations not finished after %0d ns", TIMEOUT_NS);
        $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
+incdir+.
soc_pkg.sv
bus_decoder.sv
onchip_ram.sv
ticker_timer.sv
gpio_port.sv
soc_bus_top.sv
tb_clock_gen.sv
soc_bus_checker.sv
tb_monitor.sv
tb_soc_bus.sv

/* Makefile */
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module tb_soc_bus -f list.f

run: compile
	./obj_dir/Vtb_soc_bus +verilator+error+limit+1000 > sim.log 2>&1; cat sim.log
	grep -q "^Test OK$$" sim.log

clean:
	rm -rf obj_dir sim.log
